/* verilog/post_defines.svh */
`ifndef POST_DEFINES_SVH
`define POST_DEFINES_SVH

////////////////////////////////////////
// array geometry
////////////////////////////////////////

// columns of the conv array
`define POST_COLUMN_NUM 4

// lane widths, product width plus 8 bits headroom
`define POST_PIX_W_88 24
`define POST_PIX_W_18 16

// lanes per row, 2 pixels x weights x columns
`define POST_LANES_88 (2 * 1 * `POST_COLUMN_NUM)
`define POST_LANES_18 (2 * 2 * `POST_COLUMN_NUM)

// accumulator row bus from the conv core
`define POST_ROW_W 256

////////////////////////////////////////
// bias table and requantize
////////////////////////////////////////

`define POST_BIAS_W     8
`define POST_BIAS_SET_W 16
`define POST_BIAS_DEPTH 8
`define POST_ADDR_W     3

`define POST_SHIFT_W 4

// output row of 16 unsigned bytes
`define POST_OUT_W 128

`endif

/* verilog/post_pkg.sv */
`default_nettype none

package post_pkg;

  ////////////////////////////////////////
  // command decode
  ////////////////////////////////////////

  // host command opcode, qualified by cmd_valid
  typedef enum logic [1:0] {
    op_nop       = 2'b00,
    op_load_bias = 2'b01,
    op_config    = 2'b10,
    op_row       = 2'b11
  } post_op_e;

  ////////////////////////////////////////
  // precision
  ////////////////////////////////////////

  // mode_88 is one bias on 8 wide lanes
  // mode_18 is two biases on 16 narrow lanes
  typedef enum logic {
    mode_88 = 1'b0,
    mode_18 = 1'b1
  } prec_mode_e;

endpackage

`default_nettype wire

/* verilog/post_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "post_defines.svh"

////////////////////////////////////////
// decode to execute
////////////////////////////////////////

interface bias_row_if;
  // one cycle strobe for the fields below
  logic                        valid;
  post_pkg::prec_mode_e        mode;
  logic [`POST_SHIFT_W-1:0]    shift;
  // raw accumulator row
  logic [`POST_ROW_W-1:0]      row;
  // high byte only used in mode_18
  logic [`POST_BIAS_SET_W-1:0] bias_set;

  modport decode_mp (
    output valid, mode, shift, row, bias_set
  );

  modport exec_mp (
    input valid, mode, shift, row, bias_set
  );
endinterface

////////////////////////////////////////
// execute to result
////////////////////////////////////////

interface sum_row_if;
  logic                     valid;
  post_pkg::prec_mode_e     mode;
  logic [`POST_SHIFT_W-1:0] shift;
  // biased lanes, each wraps in its own width
  logic [`POST_ROW_W-1:0]   sum;

  modport exec_mp (
    output valid, mode, shift, sum
  );

  modport result_mp (
    input valid, mode, shift, sum
  );
endinterface

`default_nettype wire

/* verilog/bias_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "post_defines.svh"

module bias_decode (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cmd_valid,
  input  post_pkg::post_op_e          cmd_op,
  input  logic [`POST_ADDR_W-1:0]     cmd_addr,
  input  logic [`POST_BIAS_SET_W-1:0] cmd_data,
  input  logic [`POST_ROW_W-1:0]      row_in,
  bias_row_if.decode_mp               br
);

  // per channel bias sets
  logic [`POST_BIAS_SET_W-1:0] bias_tab [`POST_BIAS_DEPTH];

  // layer configuration
  post_pkg::prec_mode_e     cfg_mode;
  logic [`POST_SHIFT_W-1:0] cfg_shift;

  logic do_load;
  logic do_config;
  logic do_row;

  ////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////

  // nop and idle cycles fall through
  assign do_load   = cmd_valid && (cmd_op == post_pkg::op_load_bias);
  assign do_config = cmd_valid && (cmd_op == post_pkg::op_config);
  assign do_row    = cmd_valid && (cmd_op == post_pkg::op_row);

  ////////////////////////////////////////
  // bias table and config
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `POST_BIAS_DEPTH; i++) begin
        bias_tab[i] <= '0;
      end
    end else if (do_load) begin
      bias_tab[cmd_addr] <= cmd_data;
    end
  end

  // mode in bit 0, shift in bits 7..4
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_mode  <= post_pkg::mode_88;
      cfg_shift <= '0;
    end else if (do_config) begin
      cfg_mode  <= post_pkg::prec_mode_e'(cmd_data[0]);
      cfg_shift <= cmd_data[4 +: `POST_SHIFT_W];
    end
  end

  ////////////////////////////////////////
  // row launch
  ////////////////////////////////////////

  // row carries its own bias and config snapshot
  // so later loads and configs leave it alone
  always_ff @(posedge clk) begin
    if (reset) begin
      br.valid    <= 1'b0;
      br.mode     <= post_pkg::mode_88;
      br.shift    <= '0;
      br.row      <= '0;
      br.bias_set <= '0;
    end else begin
      br.valid <= do_row;
      if (do_row) begin
        br.mode     <= cfg_mode;
        br.shift    <= cfg_shift;
        br.row      <= row_in;
        br.bias_set <= bias_tab[cmd_addr];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/bias_add.sv */
`timescale 1ns/100ps
`default_nettype none

`include "post_defines.svh"

module bias_add (
  input  logic          clk,
  input  logic          reset,
  bias_row_if.exec_mp   br,
  sum_row_if.exec_mp    sr
);

  localparam int W88   = `POST_PIX_W_88;
  localparam int W18   = `POST_PIX_W_18;
  localparam int BW    = `POST_BIAS_W;
  localparam int SUM88 = `POST_LANES_88 * `POST_PIX_W_88;
  localparam int HALF  = `POST_LANES_18 / 2;

  // bias bytes, lo shared by mode_88 and lower half of mode_18
  logic [BW-1:0] bias_lo;
  logic [BW-1:0] bias_hi;

  logic [SUM88-1:0]       sum_88;
  logic [`POST_ROW_W-1:0] sum_18;

  assign bias_lo = br.bias_set[BW-1:0];
  assign bias_hi = br.bias_set[`POST_BIAS_SET_W-1:BW];

  ////////////////////////////////////////
  // lane adders
  ////////////////////////////////////////

  // sign extended bias, sums wrap in lane width
  for (genvar i = 0; i < `POST_LANES_88; i++) begin : g_lane_88
    assign sum_88[i*W88 +: W88] = br.row[i*W88 +: W88] + {{(W88 - BW){bias_lo[BW-1]}}, bias_lo};
  end

  for (genvar i = 0; i < `POST_LANES_18; i++) begin : g_lane_18
    if (i < HALF) begin : g_lo
      // lanes 0..7 take the low byte
      assign sum_18[i*W18 +: W18] = br.row[i*W18 +: W18] + {{(W18 - BW){bias_lo[BW-1]}}, bias_lo};
    end else begin : g_hi
      // lanes 8..15 take the high byte
      assign sum_18[i*W18 +: W18] = br.row[i*W18 +: W18] + {{(W18 - BW){bias_hi[BW-1]}}, bias_hi};
    end
  end

  ////////////////////////////////////////
  // sum register
  ////////////////////////////////////////

  // incoming valid acts as enable, sum held otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      sr.valid <= 1'b0;
      sr.mode  <= post_pkg::mode_88;
      sr.shift <= '0;
      sr.sum   <= '0;
    end else begin
      sr.valid <= br.valid;
      if (br.valid) begin
        sr.mode  <= br.mode;
        sr.shift <= br.shift;
        // upper bits zero in mode_88
        sr.sum   <= (br.mode == post_pkg::mode_18) ? sum_18 : {{(`POST_ROW_W - SUM88){1'b0}}, sum_88};
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/requant_result.sv */
`timescale 1ns/100ps
`default_nettype none

`include "post_defines.svh"

module requant_result (
  input  logic                   clk,
  input  logic                   reset,
  sum_row_if.result_mp           sr,
  output logic                   out_valid,
  output logic [`POST_OUT_W-1:0] out_row
);

  localparam int W88    = `POST_PIX_W_88;
  localparam int W18    = `POST_PIX_W_18;
  localparam int BYTE_W = `POST_OUT_W / `POST_LANES_18;
  localparam int OUT88  = `POST_LANES_88 * BYTE_W;

  logic [OUT88-1:0]       bytes_88;
  logic [`POST_OUT_W-1:0] bytes_18;

  ////////////////////////////////////////
  // lane requantize
  ////////////////////////////////////////

  // relu, arithmetic shift, clamp to 255
  function automatic logic [BYTE_W-1:0] requant(
    input logic signed [W88-1:0]     lane,
    input logic [`POST_SHIFT_W-1:0]  sh
  );
    logic signed [W88-1:0] shifted;
    begin
      shifted = lane >>> sh;
      if (lane < 0) begin
        requant = '0;
      end else if (shifted > 255) begin
        requant = '1;
      end else begin
        requant = shifted[BYTE_W-1:0];
      end
    end
  endfunction

  // wide lanes go straight in
  for (genvar i = 0; i < `POST_LANES_88; i++) begin : g_byte_88
    assign bytes_88[i*BYTE_W +: BYTE_W] = requant(sr.sum[i*W88 +: W88], sr.shift);
  end

  // narrow lanes sign extended to the wide form
  for (genvar i = 0; i < `POST_LANES_18; i++) begin : g_byte_18
    assign bytes_18[i*BYTE_W +: BYTE_W] =
      requant({{(W88 - W18){sr.sum[i*W18 + W18 - 1]}}, sr.sum[i*W18 +: W18]}, sr.shift);
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  // lane i lands in byte i, row held between pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_row   <= '0;
    end else begin
      out_valid <= sr.valid;
      if (sr.valid) begin
        // bytes 8..15 zero in mode_88
        out_row <= (sr.mode == post_pkg::mode_18) ? bytes_18 : {{(`POST_OUT_W - OUT88){1'b0}}, bytes_88};
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/post_process_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "post_defines.svh"

module post_process_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cmd_valid,
  input  post_pkg::post_op_e          cmd_op,
  input  logic [`POST_ADDR_W-1:0]     cmd_addr,
  input  logic [`POST_BIAS_SET_W-1:0] cmd_data,
  input  logic [`POST_ROW_W-1:0]      row_in,
  output logic                        out_valid,
  output logic [`POST_OUT_W-1:0]      out_row
);

  ////////////////////////////////////////
  // stage links
  ////////////////////////////////////////

  bias_row_if br_bus ();
  sum_row_if  sr_bus ();

  ////////////////////////////////////////
  // decode, execute, result
  ////////////////////////////////////////

  // command decode, bias table, row launch
  bias_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .row_in    (row_in),
    .br        (br_bus.decode_mp)
  );

  // per lane bias add
  bias_add u_add (
    .clk   (clk),
    .reset (reset),
    .br    (br_bus.exec_mp),
    .sr    (sr_bus.exec_mp)
  );

  // relu, shift, saturate to bytes
  requant_result u_result (
    .clk       (clk),
    .reset     (reset),
    .sr        (sr_bus.result_mp),
    .out_valid (out_valid),
    .out_row   (out_row)
  );

endmodule

`default_nettype wire

/* sim/post_process_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "post_defines.svh"

module post_process_tb;

  // commands issued per test, sets the run limit
  localparam int N_T1 = 4;
  localparam int N_T2 = 109;
  localparam int N_T3 = 109;
  localparam int N_T4 = 60;
  localparam int N_T5 = 40;
  localparam int N_T6 = 38;
  localparam int LIMIT = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6 + 3 * 6 + 50;

  logic                        clk;
  logic                        reset;
  logic                        cmd_valid;
  post_pkg::post_op_e          cmd_op;
  logic [`POST_ADDR_W-1:0]     cmd_addr;
  logic [`POST_BIAS_SET_W-1:0] cmd_data;
  logic [`POST_ROW_W-1:0]      row_in;
  logic                        out_valid;
  logic [`POST_OUT_W-1:0]      out_row;

  int          seed = 32'h5ae8b5ab;
  int          cycle = 0;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          test_err0 = 0;
  logic [31:0] rnd;

  // mirror of bias table and layer config
  logic [`POST_BIAS_SET_W-1:0] mdl_bias [`POST_BIAS_DEPTH];
  logic                        mdl_mode18;
  int                          mdl_shift;

  // expected rows and their issue edge
  logic [`POST_OUT_W-1:0] exp_q [$];
  int                     iss_q [$];
  logic [`POST_OUT_W-1:0] mon_exp;
  int                     mon_iss;

  post_process_top u_dut (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // edge counter and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= LIMIT) begin
      $display("timeout after %0d cycles, the run did not complete", cycle);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // bias, wrap, relu, shift, clamp per lane
  function automatic logic [`POST_OUT_W-1:0] model_row(
    input logic [`POST_ROW_W-1:0]      row,
    input logic [`POST_BIAS_SET_W-1:0] bset,
    input logic                        mode18,
    input int                          sh
  );
    logic [`POST_OUT_W-1:0] res;
    logic [`POST_ROW_W-1:0] tmp;
    longint                 mask;
    longint                 lane;
    longint                 b;
    int                     n;
    int                     w;
    res = '0;
    n = mode18 ? 16 : 8;
    w = mode18 ? 16 : 24;
    mask = (longint'(1) << w) - 1;
    for (int i = 0; i < n; i++) begin
      tmp = row >> (i * w);
      lane = longint'(tmp[31:0]) & mask;
      // upper half of mode_18 takes the high bias byte
      b = (mode18 && i >= 8) ? longint'($signed(bset[15:8])) : longint'($signed(bset[7:0]));
      lane = (lane + b) & mask;
      // back to a signed lane value
      if (lane > mask / 2) lane = lane - (mask + 1);
      if (lane < 0) lane = 0;
      lane = lane >> sh;
      if (lane > 255) lane = 255;
      res[i*8 +: 8] = lane[7:0];
    end
    return res;
  endfunction

  function automatic logic [`POST_ROW_W-1:0] rand_row();
    logic [`POST_ROW_W-1:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i*32 +: 32] = $random(seed);
    end
    return r;
  endfunction

  // all lanes at signed max, signed min, -1 or 200
  function automatic logic [`POST_ROW_W-1:0] edge_row(input logic mode18, input int kind);
    logic [`POST_ROW_W-1:0] r;
    logic [`POST_ROW_W-1:0] v;
    longint                 val;
    int                     w;
    w = mode18 ? 16 : 24;
    case (kind)
      0: val = (longint'(1) << (w - 1)) - 1;
      1: val = longint'(1) << (w - 1);
      2: val = (longint'(1) << w) - 1;
      default: val = 200;
    endcase
    r = '0;
    v = '0;
    v[63:0] = val;
    for (int i = 0; i < (mode18 ? 16 : 8); i++) begin
      r = r | (v << (i * w));
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////

  // one command per edge, model follows it
  task automatic send_cmd(
    input post_pkg::post_op_e          op,
    input logic [`POST_ADDR_W-1:0]     addr,
    input logic [`POST_BIAS_SET_W-1:0] data,
    input logic [`POST_ROW_W-1:0]      row
  );
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_addr  <= addr;
    cmd_data  <= data;
    row_in    <= row;
    case (op)
      post_pkg::op_load_bias: mdl_bias[addr] = data;
      post_pkg::op_config: begin
        mdl_mode18 = data[0];
        mdl_shift  = int'(data[7:4]);
      end
      post_pkg::op_row: begin
        exp_q.push_back(model_row(row, mdl_bias[addr], mdl_mode18, mdl_shift));
        // counter still shows the previous edge here
        iss_q.push_back(cycle + 1);
      end
      default: ;
    endcase
  endtask

  // cmd_valid low, fields random
  task automatic idle_cmd();
    logic [31:0] r;
    r = $random(seed);
    @(posedge clk);
    cmd_valid <= 1'b0;
    cmd_op    <= post_pkg::post_op_e'(r[1:0]);
    cmd_addr  <= r[4:2];
    cmd_data  <= r[31:16];
    row_in    <= rand_row();
  endtask

  // drain, then tally this test
  task automatic end_test(input string name);
    repeat (3) idle_cmd();
    // last out_valid lands on the fourth edge, its check on the negedge after
    repeat (2) @(posedge clk);
    if (err_cnt == test_err0) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - test_err0);
    end
    test_err0 = err_cnt;
  endtask

  task automatic random_mode_test(input logic mode18);
    logic [31:0] r;
    for (int a = 0; a < `POST_BIAS_DEPTH; a++) begin
      r = $random(seed);
      send_cmd(post_pkg::op_load_bias, a[2:0], r[15:0], '0);
    end
    r = $random(seed);
    send_cmd(post_pkg::op_config, '0, {8'h00, r[3:0], 3'b000, mode18}, '0);
    for (int k = 0; k < 100; k++) begin
      r = $random(seed);
      send_cmd(post_pkg::op_row, r[2:0], '0, rand_row());
    end
  endtask

  ////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (out_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("[%0t] out_valid pulsed with no row pending", $time);
        err_cnt++;
      end
      if (exp_q.size() > 0) begin
        mon_exp = exp_q.pop_front();
        mon_iss = iss_q.pop_front();
        assert (cycle == mon_iss + 3) else begin
          $display("[%0t] row issued at cycle %0d came out at cycle %0d", $time, mon_iss, cycle);
          err_cnt++;
        end
        assert (out_row === mon_exp) else begin
          $display("[ERROR] %0t out_row expected %h got %h", $time, mon_exp, out_row);
          err_cnt++;
        end
      end
    end else begin
      // missing pulse for the oldest row
      assert (exp_q.size() == 0 || cycle < iss_q[0] + 3) else begin
        $display("[%0t] row issued at cycle %0d gave no out_valid 3 cycles later",
                 $time, iss_q[0]);
        err_cnt++;
        void'(exp_q.pop_front());
        void'(iss_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    reset     <= 1'b1;
    cmd_valid <= 1'b0;
    cmd_op    <= post_pkg::op_nop;
    cmd_addr  <= '0;
    cmd_data  <= '0;
    row_in    <= '0;
    mdl_mode18 = 1'b0;
    mdl_shift  = 0;
    for (int i = 0; i < `POST_BIAS_DEPTH; i++) begin
      mdl_bias[i] = '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // cleared table, mode_88, shift 0
    repeat (3) idle_cmd();
    rnd = $random(seed);
    send_cmd(post_pkg::op_row, rnd[2:0], '0, rand_row());
    end_test("reset_state");

    random_mode_test(1'b0);
    end_test("mode_88_random");
    random_mode_test(1'b1);
    end_test("mode_18_random");

    // back to back rows, config and loads in between
    for (int k = 0; k < N_T4; k++) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd2: send_cmd(post_pkg::op_config, '0, {8'h00, rnd[7:4], 3'b000, rnd[8]}, '0);
        2'd3: send_cmd(post_pkg::op_load_bias, rnd[6:4], rnd[31:16], '0);
        default: send_cmd(post_pkg::op_row, rnd[6:4], '0, rand_row());
      endcase
    end
    end_test("pipeline_config");

    // nothing here may pulse out_valid
    for (int k = 0; k < N_T5; k++) begin
      rnd = $random(seed);
      case (k % 4)
        0: send_cmd(post_pkg::op_nop, rnd[2:0], rnd[31:16], rand_row());
        1: idle_cmd();
        2: send_cmd(post_pkg::op_load_bias, rnd[2:0], rnd[31:16], '0);
        default: send_cmd(post_pkg::op_config, '0, rnd[15:0], '0);
      endcase
    end
    end_test("idle_commands");

    // bias +127 low / -128 high, and the reverse
    send_cmd(post_pkg::op_load_bias, 3'd0, 16'h807f, '0);
    send_cmd(post_pkg::op_load_bias, 3'd1, 16'h7f80, '0);
    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 2; s++) begin
        send_cmd(post_pkg::op_config, '0, {8'h00, (s == 1) ? 4'hf : 4'h0, 3'b000, m[0]}, '0);
        for (int kind = 0; kind < 4; kind++) begin
          send_cmd(post_pkg::op_row, 3'd0, '0, edge_row(m[0], kind));
          send_cmd(post_pkg::op_row, 3'd1, '0, edge_row(m[0], kind));
        end
      end
    end
    end_test("extremes");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* post_process_top.f */
+incdir+verilog
verilog/post_pkg.sv
verilog/post_if.sv
verilog/bias_decode.sv
verilog/bias_add.sv
verilog/requant_result.sv
verilog/post_process_top.sv
sim/post_process_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the post processing testbench under Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f post_process_top.f \
  --top-module post_process_tb \
  --Mdir obj_dir -o post_process_sim

./obj_dir/post_process_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
fi
exit 1
